// File: Makefile
SRCS := $(filter %.sv,$(shell cat sources.f)) fscpu_defines.svh

all: run

obj_dir/Vtb_fscpu: sources.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_fscpu -f sources.f

run: obj_dir/Vtb_fscpu
	./obj_dir/Vtb_fscpu | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: discharge_pwm.sv
`timescale 1ns/1ns
`include "fscpu_defines.svh"

module discharge_pwm
	import fscpu_pkg::*;
(
	input  logic           clk,
	input  logic           resetn,
	input  logic           enable,
	input  discharge_req_t dreq,
	input  pwm_cnt_t       denominator,
	output logic           drive,
	output logic           exe_done
);

	discharge_state_e             state;
	pwm_cnt_t                     pwm_cnt;
	logic [`FSCPU_PWM_CNT_W:0]    pwm_cnt_inc;
	pwm_num_t                     period_cnt;
	pwm_num_t                     period_next;
	pwm_num_t                     cur_number;
	pwm_cnt_t                     cur_numerator;
	logic                         period_end;
	logic                         phase_end;
	logic                         active;

	assign active        = (state == ds_phase0) || (state == ds_phase1);
	assign cur_number    = (state == ds_phase1) ? dreq.number1 : dreq.number0;
	assign cur_numerator = (state == ds_phase1) ? dreq.numerator1 : dreq.numerator0;

	// extra bit keeps a full-scale denominator from wrapping
	assign pwm_cnt_inc = {1'b0, pwm_cnt} + 1'b1;
	assign period_end  = pwm_cnt_inc >= {1'b0, denominator};
	assign period_next = period_cnt + 1'b1;
	assign phase_end   = period_end && (period_next == cur_number);

	always_ff @(posedge clk) begin
		if (!resetn || !enable) begin
			state      <= ds_idle;
			pwm_cnt    <= '0;
			period_cnt <= '0;
		end else begin
			case (state)
				// phases with no periods are skipped
				ds_idle: begin
					pwm_cnt    <= '0;
					period_cnt <= '0;
					if (dreq.number0 != '0) begin
						state <= ds_phase0;
					end else if (dreq.number1 != '0) begin
						state <= ds_phase1;
					end else begin
						state <= ds_done;
					end
				end
				ds_phase0, ds_phase1: begin
					pwm_cnt <= period_end ? '0 : pwm_cnt_inc[`FSCPU_PWM_CNT_W-1:0];
					if (phase_end) begin
						period_cnt <= '0;
						if ((state == ds_phase0) && (dreq.number1 != '0)) begin
							state <= ds_phase1;
						end else begin
							state <= ds_done;
						end
					end else if (period_end) begin
						period_cnt <= period_next;
					end
				end
				default: begin
					state <= ds_done;
				end
			endcase
		end
	end

	// high for the first numerator cycles of each period
	assign drive    = enable && active && (pwm_cnt < cur_numerator);
	assign exe_done = enable && (state == ds_done);

endmodule

// File: fscpu_defines.svh
`ifndef FSCPU_DEFINES_SVH
`define FSCPU_DEFINES_SVH

// data widths
`define FSCPU_SPEED_W      32
`define FSCPU_STEP_W       32
`define FSCPU_PWM_CNT_W    16
`define FSCPU_PWM_NUM_W    32

// device counts
`define FSCPU_NUM_MOTORS   4
`define FSCPU_NUM_DEVS     5

// bitmap index of the discharge channel, motors sit at 0 to 3
`define FSCPU_DEV_DISCHARGE_BIT 4

// command codes, motor commands use their bitmap index
`define FSCPU_CMD_DISCHARGE 8
`define FSCPU_CMD_CFG       29
`define FSCPU_CMD_EXE       30
`define FSCPU_CMD_STOP      31

`endif

// File: fscpu_exec_ctl.sv
`timescale 1ns/1ns
`include "fscpu_defines.svh"

module fscpu_exec_ctl
	import fscpu_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  req_t     req,
	input  logic     stage_strobe,
	input  dev_bmp_t stage_bit,
	input  dev_bmp_t exe_done,
	output dev_bmp_t oper,
	output logic     req_done
);

	dev_bmp_t staged;
	logic     exe_cmd;
	logic     stop_cmd;
	logic     all_done;

	assign exe_cmd  = req.en && (req.cmd == `FSCPU_CMD_EXE);
	assign stop_cmd = req.en && (req.cmd == `FSCPU_CMD_STOP);

	// every operating device reports done
	assign all_done = (oper != '0) && ((exe_done & oper) == oper);

	// devices staged since the last non-device command
	always_ff @(posedge clk) begin
		if (!resetn) begin
			staged <= '0;
		end else if (req.en) begin
			if (stage_strobe) begin
				staged <= staged | stage_bit;
			end else begin
				staged <= '0;
			end
		end
	end

	// a cleared bit holds its channel idle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			oper <= '0;
		end else if (exe_cmd) begin
			oper <= staged;
		end else if (stop_cmd || all_done) begin
			oper <= '0;
		end
	end

	// held until the host sends the next request
	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_done <= 1'b0;
		end else if (all_done && !exe_cmd) begin
			req_done <= 1'b1;
		end else if (req.en) begin
			req_done <= 1'b0;
		end
	end

	// completion must retire the run in the same edge
	assert property (@(posedge clk) disable iff (!resetn)
		!(req_done && (oper != '0)))
	else
		$error("req_done high while devices still operating: %b", oper);

endmodule

// File: fscpu_pkg.sv
`include "fscpu_defines.svh"

package fscpu_pkg;

	typedef logic [`FSCPU_SPEED_W-1:0]   speed_t;
	typedef logic [`FSCPU_STEP_W-1:0]    step_t;
	typedef logic [`FSCPU_PWM_CNT_W-1:0] pwm_cnt_t;
	typedef logic [`FSCPU_PWM_NUM_W-1:0] pwm_num_t;
	typedef logic [`FSCPU_NUM_DEVS-1:0]  dev_bmp_t;

	// host request, en is a one-cycle strobe
	typedef struct packed {
		logic        en;
		logic [31:0] cmd;
		logic [31:0] par0;
		logic [31:0] par1;
		logic [31:0] par2;
		logic [31:0] par3;
	} req_t;

	typedef struct packed {
		logic   dir_back;
		speed_t speed;
		step_t  step;
	} motor_req_t;

	typedef struct packed {
		pwm_cnt_t numerator0;
		pwm_cnt_t numerator1;
		pwm_num_t number0;
		pwm_num_t number1;
	} discharge_req_t;

	// move as seen by the external motor driver
	typedef struct packed {
		logic   start;
		logic   stop;
		speed_t speed;
		step_t  step;
		logic   dir;
	} motor_cmd_t;

	typedef enum logic [2:0] {
		ms_idle,
		ms_launch,
		ms_wait_busy,
		ms_wait_idle,
		ms_done
	} motor_state_e;

	typedef enum logic [1:0] {
		ds_idle,
		ds_phase0,
		ds_phase1,
		ds_done
	} discharge_state_e;

endpackage

// File: fscpu_req_regs.sv
`timescale 1ns/1ns
`include "fscpu_defines.svh"

module fscpu_req_regs
	import fscpu_pkg::*;
(
	input  logic                                   clk,
	input  logic                                   resetn,
	input  req_t                                   req,
	output motor_req_t [`FSCPU_NUM_MOTORS-1:0]     motor_req,
	output discharge_req_t                         discharge_req,
	output pwm_cnt_t                               denominator,
	output logic                                   stage_strobe,
	output dev_bmp_t                               stage_bit
);

	logic cfg_hit;
	logic discharge_hit;

	assign cfg_hit       = req.en && (req.cmd == `FSCPU_CMD_CFG);
	assign discharge_hit = req.en && (req.cmd == `FSCPU_CMD_DISCHARGE);

	// per motor move parameters
	for (genvar i = 0; i < `FSCPU_NUM_MOTORS; i++) begin : g_motor_req
		always_ff @(posedge clk) begin
			if (req.en && (req.cmd == i)) begin
				motor_req[i].dir_back <= req.par0[1];
				motor_req[i].speed    <= req.par1[`FSCPU_SPEED_W-1:0];
				motor_req[i].step     <= req.par2[`FSCPU_STEP_W-1:0];
			end
		end
	end

	// two-phase pwm settings
	always_ff @(posedge clk) begin
		if (discharge_hit) begin
			discharge_req.numerator0 <= req.par0[`FSCPU_PWM_CNT_W-1:0];
			discharge_req.numerator1 <= req.par0[16 +: `FSCPU_PWM_CNT_W];
			discharge_req.number0    <= req.par1[`FSCPU_PWM_NUM_W-1:0];
			discharge_req.number1    <= req.par2[`FSCPU_PWM_NUM_W-1:0];
		end
	end

	// pwm period length from the configuration command
	always_ff @(posedge clk) begin
		if (!resetn) begin
			denominator <= '0;
		end else if (cfg_hit) begin
			denominator <= req.par2[`FSCPU_PWM_CNT_W-1:0];
		end
	end

	// device command decode for staging
	always_comb begin
		stage_bit = '0;
		for (int k = 0; k < `FSCPU_NUM_MOTORS; k++) begin
			if (req.cmd == k) begin
				stage_bit[k] = 1'b1;
			end
		end
		if (req.cmd == `FSCPU_CMD_DISCHARGE) begin
			stage_bit[`FSCPU_DEV_DISCHARGE_BIT] = 1'b1;
		end
		if (!req.en) begin
			stage_bit = '0;
		end
	end

	// any motor code or the discharge code
	assign stage_strobe = discharge_hit || (req.en && (req.cmd < `FSCPU_NUM_MOTORS));

	// execute control relies on a single staged device per strobe
	assert property (@(posedge clk) disable iff (!resetn)
		stage_strobe |-> $onehot(stage_bit))
	else
		$error("stage_bit not one-hot: %b", stage_bit);

endmodule

// File: fscpu_top.sv
`timescale 1ns/1ns
`include "fscpu_defines.svh"

module fscpu_top
	import fscpu_pkg::*;
(
	input  logic                               clk,
	input  logic                               resetn,
	input  req_t                               req,
	input  logic [`FSCPU_NUM_MOTORS-1:0]       motor_busy,
	output motor_cmd_t [`FSCPU_NUM_MOTORS-1:0] motor_cmd,
	output logic                               discharge_drive,
	output logic                               req_done
);

	motor_req_t [`FSCPU_NUM_MOTORS-1:0] motor_req;
	discharge_req_t                     discharge_req;
	pwm_cnt_t                           denominator;
	logic                               stage_strobe;
	dev_bmp_t                           stage_bit;
	dev_bmp_t                           oper;
	dev_bmp_t                           exe_done;

	fscpu_req_regs i_req_regs (
		.clk          (clk),
		.resetn       (resetn),
		.req          (req),
		.motor_req    (motor_req),
		.discharge_req(discharge_req),
		.denominator  (denominator),
		.stage_strobe (stage_strobe),
		.stage_bit    (stage_bit)
	);

	fscpu_exec_ctl i_exec_ctl (
		.clk         (clk),
		.resetn      (resetn),
		.req         (req),
		.stage_strobe(stage_strobe),
		.stage_bit   (stage_bit),
		.exe_done    (exe_done),
		.oper        (oper),
		.req_done    (req_done)
	);

	// left push, right push, x align, y align
	for (genvar g = 0; g < `FSCPU_NUM_MOTORS; g++) begin : g_motor
		motor_ctl i_motor (
			.clk     (clk),
			.resetn  (resetn),
			.enable  (oper[g]),
			.mreq    (motor_req[g]),
			.busy    (motor_busy[g]),
			.cmd     (motor_cmd[g]),
			.exe_done(exe_done[g])
		);
	end

	discharge_pwm i_discharge (
		.clk        (clk),
		.resetn     (resetn),
		.enable     (oper[`FSCPU_DEV_DISCHARGE_BIT]),
		.dreq       (discharge_req),
		.denominator(denominator),
		.drive      (discharge_drive),
		.exe_done   (exe_done[`FSCPU_DEV_DISCHARGE_BIT])
	);

endmodule

// File: motor_ctl.sv
`timescale 1ns/1ns

module motor_ctl
	import fscpu_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       enable,
	input  motor_req_t mreq,
	input  logic       busy,
	output motor_cmd_t cmd,
	output logic       exe_done
);

	motor_state_e state;
	motor_state_e state_next;
	speed_t       speed_q;
	step_t        step_q;
	logic         dir_q;
	logic         moving;

	always_comb begin
		state_next = state;
		if (!enable) begin
			state_next = ms_idle;
		end else begin
			case (state)
				ms_idle: begin
					state_next = ms_launch;
				end
				ms_launch: begin
					state_next = ms_wait_busy;
				end
				// driver takes a while to pick up the move
				ms_wait_busy: begin
					if (busy) begin
						state_next = ms_wait_idle;
					end
				end
				ms_wait_idle: begin
					if (!busy) begin
						state_next = ms_done;
					end
				end
				ms_done: begin
					state_next = ms_done;
				end
				default: begin
					state_next = ms_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ms_idle;
		end else begin
			state <= state_next;
		end
	end

	// capture the move as it is launched
	always_ff @(posedge clk) begin
		if ((state == ms_idle) && enable) begin
			speed_q <= mreq.speed;
			step_q  <= mreq.step;
			dir_q   <= mreq.dir_back;
		end
	end

	assign moving = (state == ms_launch) || (state == ms_wait_busy) ||
	                (state == ms_wait_idle);

	always_comb begin
		cmd.start = (state == ms_launch) && enable;
		// disabled mid-move, state returns to idle on the next edge
		cmd.stop  = moving && !enable;
		cmd.speed = speed_q;
		cmd.step  = step_q;
		cmd.dir   = dir_q;
	end

	assign exe_done = enable && (state == ms_done);

	// one move per enable
	assert property (@(posedge clk) disable iff (!resetn)
		cmd.start |=> !cmd.start)
	else
		$error("motor start held for more than one cycle");

endmodule

// File: sources.f
+incdir+.
fscpu_pkg.sv
fscpu_req_regs.sv
fscpu_exec_ctl.sv
motor_ctl.sv
discharge_pwm.sv
fscpu_top.sv
tb_motor_model.sv
tb_fscpu.sv

// File: tb_fscpu.sv
`timescale 1ns/1ns
`include "fscpu_defines.svh"

module tb_fscpu
	import fscpu_pkg::*;
();

	logic                               clk;
	logic                               resetn;
	req_t                               req;
	logic [`FSCPU_NUM_MOTORS-1:0]       motor_busy;
	logic [`FSCPU_NUM_MOTORS-1:0]       busy_q;
	logic [`FSCPU_NUM_MOTORS-1:0]       busy_fell;
	motor_cmd_t [`FSCPU_NUM_MOTORS-1:0] motor_cmd;
	logic                               discharge_drive;
	logic                               req_done;
	logic                               rst_check;
	logic                               clear_counts;
	logic                               count_check;
	logic                               done_allowed;
	dev_bmp_t                           expect_run;
	logic [64:0]                        exp_move [`FSCPU_NUM_MOTORS];
	int                                 start_cnt [`FSCPU_NUM_MOTORS];
	int                                 stop_cnt [`FSCPU_NUM_MOTORS];
	int                                 drive_cnt;
	int                                 exp_drive;
	int                                 count_act;
	int                                 count_exp;
	int                                 err_cnt;
	int                                 timeout_cnt;
	int                                 seed = 32'ha64a_c995;
	string                              test_name;
	string                              count_what;

	initial begin
		clk = 1'b0;
		forever begin
			#50;
			clk = ~clk;
		end
	end

	fscpu_top i_dut (
		.clk            (clk),
		.resetn         (resetn),
		.req            (req),
		.motor_busy     (motor_busy),
		.motor_cmd      (motor_cmd),
		.discharge_drive(discharge_drive),
		.req_done       (req_done)
	);

	for (genvar g = 0; g < `FSCPU_NUM_MOTORS; g++) begin : g_motor
		tb_motor_model i_model (
			.clk   (clk),
			.resetn(resetn),
			.cmd   (motor_cmd[g]),
			.busy  (motor_busy[g])
		);

		assert property (@(posedge clk) rst_check |-> !motor_cmd[g].start && !motor_cmd[g].stop)
		else begin
			$display("reset: motor %0d start or stop went high around reset", g);
			err_cnt++;
		end

		assert property (@(posedge clk) disable iff (!resetn)
			motor_cmd[g].start |-> expect_run[g])
		else begin
			$display("%s: motor %0d started without being staged", test_name, g);
			err_cnt++;
		end

		assert property (@(posedge clk) disable iff (!resetn) motor_cmd[g].start |->
			({motor_cmd[g].dir, motor_cmd[g].speed, motor_cmd[g].step} == exp_move[g]))
		else begin
			$display("error: %s motor %0d move expected %h actual %h", test_name, g, exp_move[g],
				{motor_cmd[g].dir, motor_cmd[g].speed, motor_cmd[g].step});
			err_cnt++;
		end

		assert property (@(posedge clk) disable iff (!resetn)
			motor_cmd[g].start |=> !motor_cmd[g].start)
		else begin
			$display("%s: motor %0d start lasted more than one cycle", test_name, g);
			err_cnt++;
		end
	end

	assert property (@(posedge clk) rst_check |-> !discharge_drive && !req_done)
	else begin
		$display("reset: drive or req_done went high around reset");
		err_cnt++;
	end

	assert property (@(posedge clk) disable iff (!resetn) discharge_drive |-> expect_run[4])
	else begin
		$display("%s: discharge drive active without being staged", test_name);
		err_cnt++;
	end

	// completion only once every staged device has finished
	assert property (@(posedge clk) disable iff (!resetn) $rose(req_done) |->
		(((busy_fell & expect_run[3:0]) == expect_run[3:0]) && (drive_cnt == exp_drive)))
	else begin
		$display("error: %s early req_done expected drive %0d actual %0d, busy fell %b of %b",
			test_name, exp_drive, drive_cnt, busy_fell, expect_run[3:0]);
		err_cnt++;
	end

	assert property (@(posedge clk) disable iff (!resetn) req_done && !req.en |=> req_done)
	else begin
		$display("%s: req_done dropped without a new request", test_name);
		err_cnt++;
	end

	assert property (@(posedge clk) disable iff (!resetn) req_done |-> done_allowed)
	else begin
		$display("%s: req_done rose although no run should complete", test_name);
		err_cnt++;
	end

	assert property (@(posedge clk) count_check |-> (count_act == count_exp))
	else begin
		$display("error: %s %s expected %0d actual %0d", test_name, count_what, count_exp,
			count_act);
		err_cnt++;
	end

	// pulse and finish bookkeeping per test
	always_ff @(posedge clk) begin
		if (!resetn || clear_counts) begin
			drive_cnt <= 0;
			busy_fell <= '0;
			for (int i = 0; i < `FSCPU_NUM_MOTORS; i++) begin
				start_cnt[i] <= 0;
				stop_cnt[i]  <= 0;
			end
		end else begin
			if (discharge_drive) begin
				drive_cnt <= drive_cnt + 1;
			end
			for (int i = 0; i < `FSCPU_NUM_MOTORS; i++) begin
				if (motor_cmd[i].start) begin
					start_cnt[i] <= start_cnt[i] + 1;
				end
				if (motor_cmd[i].stop) begin
					stop_cnt[i] <= stop_cnt[i] + 1;
				end
				if (busy_q[i] && !motor_busy[i]) begin
					busy_fell[i] <= 1'b1;
				end
			end
		end
		busy_q <= motor_busy;
	end

	function automatic int rand_range(input int lo, input int span);
		int unsigned r;
		r = $random(seed);
		return lo + int'(r % span);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
		end
		#10;
	endtask

	task automatic send_req(input logic [31:0] cmd, input logic [31:0] p0,
		input logic [31:0] p1, input logic [31:0] p2);
		req.en   = 1'b1;
		req.cmd  = cmd;
		req.par0 = p0;
		req.par1 = p1;
		req.par2 = p2;
		req.par3 = '0;
		idle_cycles(1);
		req.en = 1'b0;
	endtask

	task automatic send_motor(input int ch, input int step);
		logic        dir;
		logic [31:0] speed;
		dir         = (rand_range(0, 2) == 1);
		speed       = $random(seed);
		exp_move[ch] = {dir, speed, 32'(step)};
		send_req(ch, {30'b0, dir, 1'b0}, speed, step);
	endtask

	// numerators stay below the period length
	task automatic send_discharge(input int den);
		int num0;
		int num1;
		int n0;
		int n1;
		num0      = rand_range(1, den - 1);
		num1      = rand_range(1, den - 1);
		n0        = rand_range(1, 3);
		n1        = rand_range(1, 3);
		exp_drive = num0 * n0 + num1 * n1;
		send_req(`FSCPU_CMD_DISCHARGE, {16'(num1), 16'(num0)}, n0, n1);
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		clear_counts = 1'b1;
		idle_cycles(1);
		clear_counts = 1'b0;
	endtask

	task automatic check_count(input string what, input int act, input int exp);
		count_what  = what;
		count_act   = act;
		count_exp   = exp;
		count_check = 1'b1;
		idle_cycles(1);
		count_check = 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		while (!req_done && (n < limit)) begin
			idle_cycles(1);
			n++;
		end
		if (!req_done) begin
			$display("timeout: req_done never rose in test %s", test_name);
			timeout_cnt++;
		end
	endtask

	task automatic wait_busy(input int ch, input int limit);
		int n;
		n = 0;
		while (!motor_busy[ch] && (n < limit)) begin
			idle_cycles(1);
			n++;
		end
		if (!motor_busy[ch]) begin
			$display("timeout: motor %0d busy never rose in test %s", ch, test_name);
			timeout_cnt++;
		end
	endtask

	initial begin
		int den;
		req          = '0;
		resetn       = 1'b0;
		rst_check    = 1'b0;
		clear_counts = 1'b0;
		count_check  = 1'b0;
		done_allowed = 1'b0;
		expect_run   = '0;
		exp_drive    = 0;
		err_cnt      = 0;
		timeout_cnt  = 0;
		test_name    = "reset";
		for (int i = 0; i < `FSCPU_NUM_MOTORS; i++) begin
			exp_move[i] = '0;
		end
		idle_cycles(1);
		rst_check = 1'b1;
		idle_cycles(4);
		resetn = 1'b1;
		idle_cycles(3);
		rst_check = 1'b0;

		start_test("single_move");
		done_allowed = 1'b1;
		expect_run   = 5'b00010;
		send_req(`FSCPU_CMD_CFG, 0, 0, 6);
		send_motor(1, rand_range(0, 16));
		send_req(`FSCPU_CMD_EXE, 0, 0, 0);
		wait_done(200);
		idle_cycles(4);
		check_count("motor 1 starts", start_cnt[1], 1);

		start_test("combined_run");
		expect_run = 5'b10101;
		den        = rand_range(4, 4);
		send_req(`FSCPU_CMD_CFG, 0, 0, den);
		send_motor(0, rand_range(0, 16));
		send_motor(2, rand_range(0, 16));
		send_discharge(den);
		send_req(`FSCPU_CMD_EXE, 0, 0, 0);
		wait_done(400);
		check_count("motor 0 starts", start_cnt[0], 1);
		check_count("motor 2 starts", start_cnt[2], 1);
		check_count("drive cycles", drive_cnt, exp_drive);

		// stop lands while the driver is still busy
		start_test("stop");
		expect_run = 5'b00001;
		send_motor(0, 7);
		done_allowed = 1'b0;
		send_req(`FSCPU_CMD_EXE, 0, 0, 0);
		wait_busy(0, 50);
		send_req(`FSCPU_CMD_STOP, 0, 0, 0);
		idle_cycles(12);
		check_count("motor 0 stops", stop_cnt[0], 1);

		start_test("cfg_clears");
		expect_run = '0;
		send_motor(3, 3);
		send_req(`FSCPU_CMD_CFG, 0, 0, den);
		send_req(`FSCPU_CMD_EXE, 0, 0, 0);
		idle_cycles(30);
		check_count("motor 3 starts", start_cnt[3], 0);

		$display("checks failed: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if ((err_cnt == 0) && (timeout_cnt == 0)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tb_motor_model.sv
`timescale 1ns/1ns

module tb_motor_model
	import fscpu_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  motor_cmd_t cmd,
	output logic       busy
);

	int unsigned delay;
	int unsigned hold;

	// busy rises three cycles after start, length follows the step count
	always_ff @(posedge clk) begin
		if (!resetn || cmd.stop) begin
			busy  <= 1'b0;
			delay <= 0;
			hold  <= 0;
		end else if (cmd.start) begin
			delay <= 3;
			hold  <= (cmd.step % 8) + 2;
		end else if (delay != 0) begin
			delay <= delay - 1;
			if (delay == 1) begin
				busy <= 1'b1;
			end
		end else if (busy) begin
			hold <= hold - 1;
			if (hold == 1) begin
				busy <= 1'b0;
			end
		end
	end

endmodule
